// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode import soc_pkg::*; (
  input  wire logic        clock_50,
  input  wire logic        rst_n,
  input  wire bus_req_t    bus,
  output bus_sel_t         sel,
  input  wire logic [15:0] enc_data,
  input  wire logic [15:0] ser0_data,
  input  wire logic [15:0] ser1_data,
  input  wire logic [7:0]  sw,
  output logic      [15:0] rdata
);

  logic [27:0] page;
  logic [7:0]  sw_meta;
  logic [7:0]  sw_sync;

  assign page = bus.addr[31:4];

  // Switches are asynchronous to the bus clock
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      sw_meta <= 8'h00;
      sw_sync <= 8'h00;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  // Windows are disjoint, so at most one select is high
  always_comb begin
    sel      = '0;
    sel.sw   = bus.valid && (page == SW_BASE[31:4]);
    sel.enc  = bus.valid && (page == ENC_BASE[31:4]);
    sel.ser0 = bus.valid && (page == SER0_BASE[31:4]);
    sel.ser1 = bus.valid && (page == SER1_BASE[31:4]);
    sel.hex  = bus.valid && (page == HEX_BASE[31:4]);
  end

  // Each source gated by its select, then ORed
  // The hex window has nothing to read and returns zero
  assign rdata = ({16{sel.enc}}  & enc_data)
               | ({16{sel.ser0}} & ser0_data)
               | ({16{sel.ser1}} & ser1_data)
               | ({16{sel.sw}}   & {8'h00, sw_sync});

endmodule

`default_nettype wire

// File: hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display import soc_pkg::*; (
  input  wire logic     clock_50,
  input  wire logic     rst_n,
  input  wire bus_req_t bus,
  input  wire logic     select,
  output logic    [6:0] hex0,
  output logic    [6:0] hex1,
  output logic    [6:0] hex2,
  output logic    [6:0] hex3
);

  logic [15:0] shown;
  logic        wr;

  // Segments a..g in bits 0..6, low means lit
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'ha: seg7 = 7'h08;
      4'hb: seg7 = 7'h03;
      4'hc: seg7 = 7'h46;
      4'hd: seg7 = 7'h21;
      4'he: seg7 = 7'h06;
      default: seg7 = 7'h0e;
    endcase
  endfunction

  assign wr = bus.valid && select && bus.write;

  // Byte writes land in the lane picked by addr[0]
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      shown <= 16'h0000;
    end else if (wr) begin
      if (!bus.bytectl) begin
        shown <= bus.wdata;
      end else if (bus.addr[0]) begin
        shown[15:8] <= bus.wdata[7:0];
      end else begin
        shown[7:0] <= bus.wdata[7:0];
      end
    end
  end

  assign hex3 = seg7(shown[15:12]);
  assign hex2 = seg7(shown[11:8]);
  assign hex1 = seg7(shown[7:4]);
  assign hex0 = seg7(shown[3:0]);

endmodule

`default_nettype wire

// File: rgb_enc.sv
`timescale 1ns/1ps
`default_nettype none

module rgb_enc import soc_pkg::*; (
  input  wire logic        clock_50,
  input  wire logic        rst_n,
  input  wire bus_req_t    bus,
  input  wire logic        select,
  input  wire logic [1:0]  quad,
  input  wire logic        pb,
  output logic      [2:0]  rgb,
  output logic      [15:0] data_out
);

  localparam logic [4:0] POS_LAST = 5'(ENC_STEPS - 1);

  logic [1:0] quad_meta;
  logic [1:0] quad_sync;
  logic [1:0] quad_prev;
  logic       pb_meta;
  logic       pb_sync;
  logic       step_up;
  logic       step_down;
  logic       wr_pos;
  logic [4:0] pos;
  logic [2:0] colour_idx;

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      quad_meta <= 2'b00;
      quad_sync <= 2'b00;
      quad_prev <= 2'b00;
      pb_meta   <= 1'b0;
      pb_sync   <= 1'b0;
    end else begin
      quad_meta <= quad;
      quad_sync <= quad_meta;
      quad_prev <= quad_sync;
      pb_meta   <= pb;
      pb_sync   <= pb_meta;
    end
  end

  // Gray order 00, 01, 11, 10 is clockwise
  always_comb begin
    step_up   = 1'b0;
    step_down = 1'b0;
    case ({quad_prev, quad_sync})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_up   = 1'b1;
      4'b0010, 4'b1011, 4'b1101, 4'b0100: step_down = 1'b1;
      default: ;
    endcase
  end

  assign wr_pos = bus.valid && select && bus.write && (bus.addr[3:0] == ENC_REG_POS);

  // Out of range writes are dropped
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      pos <= 5'd0;
    end else if (wr_pos) begin
      if (bus.wdata < 16'(ENC_STEPS)) begin
        pos <= bus.wdata[4:0];
      end
    end else if (step_up) begin
      pos <= (pos == POS_LAST) ? 5'd0 : pos + 5'd1;
    end else if (step_down) begin
      pos <= (pos == 5'd0) ? POS_LAST : pos - 5'd1;
    end
  end

  // Eight colours, three detents each
  assign colour_idx = 3'(pos / 5'd3);

  always_comb begin
    case (colour_idx)
      3'd0:    rgb = 3'b100;
      3'd1:    rgb = 3'b110;
      3'd2:    rgb = 3'b010;
      3'd3:    rgb = 3'b011;
      3'd4:    rgb = 3'b001;
      3'd5:    rgb = 3'b101;
      3'd6:    rgb = 3'b111;
      default: rgb = 3'b000;
    endcase
  end

  always_comb begin
    case (bus.addr[3:0])
      ENC_REG_POS: data_out = {11'd0, pos};
      ENC_REG_BTN: data_out = {15'd0, pb_sync};
      default:     data_out = 16'h0000;
    endcase
  end

endmodule

`default_nettype wire

// File: soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module soc_asserts import soc_pkg::*; (
  input wire logic     clock_50,
  input wire logic     rst_n,
  input wire bus_sel_t sel,
  input wire logic     tx_busy,
  input wire logic     tx
);

  // At most one peripheral answers an access
  a_sel_onehot: assert property (@(posedge clock_50) disable iff (!rst_n) $onehot0(sel))
    else $error("more than one peripheral select is high");

  // Line rests at the stop level between frames
  a_tx_idle: assert property (@(posedge clock_50) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx line low while the transmitter is idle");

endmodule

// Decoder has no transmitter, so the idle check is held off
bind bus_decode soc_asserts chk_decode (
  .clock_50 (clock_50),
  .rst_n    (rst_n),
  .sel      (sel),
  .tx_busy  (1'b1),
  .tx       (1'b1)
);

bind uart soc_asserts chk_uart (
  .clock_50 (clock_50),
  .rst_n    (rst_n),
  .sel      (5'b00000),
  .tx_busy  (tx_busy),
  .tx       (tx)
);

`default_nettype wire

// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

  // One processor bus access, valid for a single cycle
  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] wdata;
    logic        write;
    logic        bytectl;
    logic        valid;
  } bus_req_t;

  // Peripheral selects from the address decoder
  typedef struct packed {
    logic enc;
    logic ser0;
    logic ser1;
    logic sw;
    logic hex;
  } bus_sel_t;

  // Peripheral windows, 16 bytes each, decoded on addr[31:4]
  localparam logic [31:0] SW_BASE   = 32'h0010_0000;
  localparam logic [31:0] ENC_BASE  = 32'h0010_0010;
  localparam logic [31:0] SER0_BASE = 32'h0010_0020;
  localparam logic [31:0] SER1_BASE = 32'h0010_0030;
  localparam logic [31:0] HEX_BASE  = 32'h0010_0040;

  // UART registers
  localparam logic [3:0] UART_REG_DATA   = 4'h0;
  localparam logic [3:0] UART_REG_STATUS = 4'h2;

  // UART status bits
  localparam int UART_ST_TX_BUSY  = 0;
  localparam int UART_ST_RX_VALID = 1;

  // Rotary encoder registers
  localparam logic [3:0] ENC_REG_POS = 4'h0;
  localparam logic [3:0] ENC_REG_BTN = 4'h2;

  // Detent count of one encoder turn
  localparam int ENC_STEPS = 24;

endpackage

`default_nettype wire

// File: soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
  parameter int CLK_HZ = 50_000_000,
  parameter int BAUD0  = 115200,
  parameter int BAUD1  = 9600
) (
  input  wire logic        clock_50,
  input  wire logic        rst_n,
  input  wire bus_req_t    bus,
  input  wire logic [7:0]  sw,
  input  wire logic [1:0]  quad,
  input  wire logic        pb,
  input  wire logic        serial0_rx,
  input  wire logic        serial1_rx,
  output logic      [15:0] rdata,
  output logic             serial0_tx,
  output logic             serial1_tx,
  output logic      [2:0]  rgb,
  output logic      [6:0]  hex0,
  output logic      [6:0]  hex1,
  output logic      [6:0]  hex2,
  output logic      [6:0]  hex3
);

  bus_sel_t    sel;
  logic [15:0] enc_data;
  logic [15:0] ser0_data;
  logic [15:0] ser1_data;

  // Chip selects and read data mux
  bus_decode decode0 (
    .clock_50  (clock_50),
    .rst_n     (rst_n),
    .bus       (bus),
    .sel       (sel),
    .enc_data  (enc_data),
    .ser0_data (ser0_data),
    .ser1_data (ser1_data),
    .sw        (sw),
    .rdata     (rdata)
  );

  // Console port
  uart #(.CLK_HZ(CLK_HZ), .BAUD(BAUD0)) uart0 (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .bus      (bus),
    .select   (sel.ser0),
    .rx       (serial0_rx),
    .tx       (serial0_tx),
    .data_out (ser0_data)
  );

  // Auxiliary port
  uart #(.CLK_HZ(CLK_HZ), .BAUD(BAUD1)) uart1 (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .bus      (bus),
    .select   (sel.ser1),
    .rx       (serial1_rx),
    .tx       (serial1_tx),
    .data_out (ser1_data)
  );

  rgb_enc enc0 (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .bus      (bus),
    .select   (sel.enc),
    .quad     (quad),
    .pb       (pb),
    .rgb      (rgb),
    .data_out (enc_data)
  );

  hex_display disp0 (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .bus      (bus),
    .select   (sel.hex),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3)
  );

endmodule

`default_nettype wire

// File: tb.f
soc_pkg.sv
bus_decode.sv
uart.sv
rgb_enc.sv
hex_display.sv
soc_top.sv
soc_asserts.sv
tb_soc.sv

// File: tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

  localparam int CLK_HZ = 50_000_000;
  localparam int BAUD0  = 115200;
  localparam int BAUD1  = 230400;
  localparam int DRIVE_DLY = 2;

  // One UART frame is ten bit times
  localparam int FRAME0 = 10 * (CLK_HZ / BAUD0);
  localparam int FRAME1 = 10 * (CLK_HZ / BAUD1);

  // Two loopback bytes, the dropped write pair and a quiet frame per port
  localparam int FRAME_COUNT = 4;
  localparam int WATCHDOG_CYCLES = FRAME_COUNT * (FRAME0 + FRAME1) + 2000;

  logic        clock_50;
  logic        rst_n;
  bus_req_t    bus;
  logic [7:0]  sw;
  logic [1:0]  quad;
  logic        pb;
  logic        serial0_rx;
  logic        serial1_rx;
  logic [15:0] rdata;
  logic        serial0_tx;
  logic        serial1_tx;
  logic [2:0]  rgb;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;

  int          errors;
  int          checks;
  int          tests_run;
  int          quad_idx;
  logic [31:0] rng;

  // Both ports loop back onto themselves
  assign serial0_rx = serial0_tx;
  assign serial1_rx = serial1_tx;

  soc_top #(
    .CLK_HZ (CLK_HZ),
    .BAUD0  (BAUD0),
    .BAUD1  (BAUD1)
  ) u_dut (
    .clock_50   (clock_50),
    .rst_n      (rst_n),
    .bus        (bus),
    .sw         (sw),
    .quad       (quad),
    .pb         (pb),
    .serial0_rx (serial0_rx),
    .serial1_rx (serial1_rx),
    .rdata      (rdata),
    .serial0_tx (serial0_tx),
    .serial1_tx (serial1_tx),
    .rgb        (rgb),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3)
  );

  initial begin
    clock_50 = 1'b0;
    forever #10 clock_50 = ~clock_50;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_50);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Active-low segments, g down to a
  function automatic logic [6:0] segments_for(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Red, yellow, green, cyan, blue, magenta, white, off
  function automatic logic [2:0] colour_for(input int pos);
    case (pos / 3)
      0: return 3'b100;
      1: return 3'b110;
      2: return 3'b010;
      3: return 3'b011;
      4: return 3'b001;
      5: return 3'b101;
      6: return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  function automatic logic [1:0] gray_code(input int idx);
    case (idx)
      0: return 2'b00;
      1: return 2'b01;
      2: return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  task automatic check_rdata(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s read %04h, expected %04h", $time, what, got, exp);
    end
  endtask

  task automatic check_hex(input logic [15:0] value, input string what);
    logic [27:0] got;
    logic [27:0] exp;
    got = {hex3, hex2, hex1, hex0};
    exp = {segments_for(value[15:12]), segments_for(value[11:8]),
           segments_for(value[7:4]), segments_for(value[3:0])};
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s shows segments %07h, expected %07h for %04h",
               $time, what, got, exp, value);
    end
  endtask

  task automatic check_rgb(input logic [2:0] exp, input string what);
    checks++;
    if (rgb !== exp) begin
      errors++;
      $display("FAIL %0t: %s rgb %03b, expected %03b", $time, what, rgb, exp);
    end
  endtask

  task automatic check_line(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock_50);
    #DRIVE_DLY;
  endtask

  // One request cycle; read data sampled at the falling edge
  task automatic bus_access(input logic [31:0] addr, input logic [15:0] wdata,
                            input logic write, output logic [15:0] data);
    bus_req_t req;
    req.addr    = addr;
    req.wdata   = wdata;
    req.write   = write;
    req.bytectl = 1'b0;
    req.valid   = 1'b1;
    @(posedge clock_50);
    #DRIVE_DLY;
    bus = req;
    @(negedge clock_50);
    data = rdata;
    @(posedge clock_50);
    #DRIVE_DLY;
    bus = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [15:0] wdata);
    logic [15:0] unused;
    bus_access(addr, wdata, 1'b1, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [15:0] data);
    bus_access(addr, 16'h0000, 1'b0, data);
  endtask

  task automatic quad_step(input logic forward);
    quad_idx = forward ? (quad_idx + 1) % 4 : (quad_idx + 3) % 4;
    @(posedge clock_50);
    #DRIVE_DLY;
    quad = gray_code(quad_idx);
    idle_cycles(4);
  endtask

  // Poll the status register until the looped back byte is in
  task automatic wait_rx_byte(input logic [31:0] base, input int limit, output logic ok);
    logic [15:0] st;
    int          n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      bus_read(base + 32'(UART_REG_STATUS), st);
      ok = !st[UART_ST_TX_BUSY] && st[UART_ST_RX_VALID];
      n++;
    end
    checks++;
    if (!ok) begin
      errors++;
      $display("UART at %08h never finished a loopback byte within %0d polls", base, limit);
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (errors == start_err) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_err);
    end
  endtask

  task automatic test_reset_and_switches();
    int          start_err;
    logic [15:0] d;
    logic [7:0]  val;
    start_err = errors;
    check_line(serial0_tx, 1'b1, "serial0_tx after reset");
    check_line(serial1_tx, 1'b1, "serial1_tx after reset");
    bus_read(SER0_BASE + 32'(UART_REG_STATUS), d);
    check_rdata(d, 16'h0000, "uart0 status after reset");
    bus_read(SER1_BASE + 32'(UART_REG_STATUS), d);
    check_rdata(d, 16'h0000, "uart1 status after reset");
    bus_read(ENC_BASE + 32'(ENC_REG_POS), d);
    check_rdata(d, 16'h0000, "encoder position after reset");
    check_hex(16'h0000, "hex after reset");
    check_rgb(colour_for(0), "colour after reset");
    repeat (4) begin
      rng = xorshift32(rng);
      val = rng[7:0];
      @(posedge clock_50);
      #DRIVE_DLY;
      sw = val;
      // Two flop synchronizer in front of the read mux
      idle_cycles(3);
      bus_read(SW_BASE, d);
      check_rdata(d, {8'h00, val}, "switch register");
    end
    bus_read(32'h0020_0000, d);
    check_rdata(d, 16'h0000, "unmapped address");
    bus_read(HEX_BASE, d);
    check_rdata(d, 16'h0000, "hex window");
    report_test("reset and switches", start_err);
  endtask

  task automatic test_hex_latch();
    int          start_err;
    logic [15:0] val;
    start_err = errors;
    val = 16'h0000;
    repeat (6) begin
      rng = xorshift32(rng);
      val = rng[15:0];
      bus_write(HEX_BASE, val);
      check_hex(val, "hex after write");
    end
    // Encoder offset 4 has no register behind it
    bus_write(SW_BASE, ~val);
    bus_write(ENC_BASE + 32'h4, ~val);
    bus_write(32'h0020_0000, ~val);
    check_hex(val, "hex after writes to other windows");
    report_test("hex latch", start_err);
  endtask

  task automatic test_encoder_count();
    int          start_err;
    int          pos_exp;
    int          i;
    logic [15:0] d;
    start_err = errors;
    // Still at the reset position
    pos_exp = 0;
    for (i = 0; i < 28; i++) begin
      quad_step(1'b1);
      pos_exp = (pos_exp + 1) % ENC_STEPS;
      bus_read(ENC_BASE + 32'(ENC_REG_POS), d);
      check_rdata(d, 16'(pos_exp), "position after forward step");
      check_rgb(colour_for(pos_exp), "colour after forward step");
    end
    for (i = 0; i < 6; i++) begin
      quad_step(1'b0);
      pos_exp = (pos_exp + ENC_STEPS - 1) % ENC_STEPS;
      bus_read(ENC_BASE + 32'(ENC_REG_POS), d);
      check_rdata(d, 16'(pos_exp), "position after reverse step");
      check_rgb(colour_for(pos_exp), "colour after reverse step");
    end
    report_test("encoder counting", start_err);
  endtask

  task automatic test_encoder_write_button();
    int          start_err;
    logic [15:0] d;
    start_err = errors;
    bus_write(ENC_BASE + 32'(ENC_REG_POS), 16'd17);
    bus_read(ENC_BASE + 32'(ENC_REG_POS), d);
    check_rdata(d, 16'd17, "position after writing 17");
    check_rgb(colour_for(17), "colour at 17");
    bus_write(ENC_BASE + 32'(ENC_REG_POS), 16'd30);
    bus_read(ENC_BASE + 32'(ENC_REG_POS), d);
    check_rdata(d, 16'd17, "position after writing 30");
    bus_read(ENC_BASE + 32'(ENC_REG_BTN), d);
    check_rdata(d, 16'h0000, "button released");
    @(posedge clock_50);
    #DRIVE_DLY;
    pb = 1'b1;
    idle_cycles(3);
    bus_read(ENC_BASE + 32'(ENC_REG_BTN), d);
    check_rdata(d, 16'h0001, "button held");
    pb = 1'b0;
    idle_cycles(3);
    report_test("encoder write and button", start_err);
  endtask

  task automatic test_uart_loopback(input logic [31:0] base, input int frame, input string name);
    int          start_err;
    int          k;
    logic [7:0]  b;
    logic [15:0] d;
    logic        ok;
    start_err = errors;
    for (k = 0; k < 2; k++) begin
      rng = xorshift32(rng);
      b = rng[7:0];
      bus_write(base + 32'(UART_REG_DATA), {8'h00, b});
      if (k == 0) begin
        bus_read(base + 32'(UART_REG_STATUS), d);
        check_rdata(d, 16'(1 << UART_ST_TX_BUSY), "status while sending");
      end
      wait_rx_byte(base, frame, ok);
      if (ok) begin
        bus_read(base + 32'(UART_REG_DATA), d);
        check_rdata(d, {8'h00, b}, "looped back byte");
        bus_read(base + 32'(UART_REG_STATUS), d);
        check_rdata(d, 16'h0000, "status after data read");
      end
    end
    // Second write lands while the first frame is on the line
    rng = xorshift32(rng);
    b = rng[7:0];
    bus_write(base + 32'(UART_REG_DATA), {8'h00, b});
    bus_write(base + 32'(UART_REG_DATA), {8'h00, ~b});
    wait_rx_byte(base, frame, ok);
    if (ok) begin
      bus_read(base + 32'(UART_REG_DATA), d);
      check_rdata(d, {8'h00, b}, "first of two back to back bytes");
    end
    idle_cycles(frame);
    bus_read(base + 32'(UART_REG_STATUS), d);
    check_rdata(d, 16'h0000, "status after the dropped write");
    report_test(name, start_err);
  endtask

  initial begin
    rst_n     = 1'b0;
    bus       = '0;
    sw        = 8'h00;
    quad      = 2'b00;
    pb        = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    quad_idx  = 0;
    rng       = 32'h6eafa47e;
    repeat (10) @(posedge clock_50);
    #DRIVE_DLY;
    rst_n = 1'b1;
    test_reset_and_switches();
    test_hex_latch();
    test_encoder_count();
    test_encoder_write_button();
    test_uart_loopback(SER0_BASE, FRAME0, "uart0 loopback");
    test_uart_loopback(SER1_BASE, FRAME1, "uart1 loopback");
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart import soc_pkg::*; #(
  parameter int CLK_HZ = 50_000_000,
  parameter int BAUD   = 115200
) (
  input  wire logic        clock_50,
  input  wire logic        rst_n,
  input  wire bus_req_t    bus,
  input  wire logic        select,
  input  wire logic        rx,
  output logic             tx,
  output logic      [15:0] data_out
);

  localparam int DIV   = CLK_HZ / BAUD;
  localparam int CNT_W = $clog2(DIV);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(DIV - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(DIV / 2 - 1);

  logic             wr_data;
  logic             rd_data;
  logic             tx_busy;
  logic [8:0]       tx_shift;
  logic [CNT_W-1:0] tx_cnt;
  logic [3:0]       tx_left;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_active;
  logic [CNT_W-1:0] rx_cnt;
  logic [3:0]       rx_bit;
  logic             rx_tick;
  logic             rx_store;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_buf;
  logic             rx_valid;

  assign wr_data = bus.valid && select && bus.write && (bus.addr[3:0] == UART_REG_DATA);
  assign rd_data = bus.valid && select && !bus.write && (bus.addr[3:0] == UART_REG_DATA);

  // Transmit: start bit in bit 0, stop bits shifted in from the top
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      tx_busy  <= 1'b0;
      tx_shift <= '1;
      tx_cnt   <= '0;
      tx_left  <= 4'd0;
    end else if (!tx_busy) begin
      if (wr_data) begin
        tx_shift <= {bus.wdata[7:0], 1'b0};
        tx_busy  <= 1'b1;
        tx_cnt   <= '0;
        tx_left  <= 4'd9;
      end
    end else if (tx_cnt == BIT_LAST) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[8:1]};
      if (tx_left == 4'd0) begin
        tx_busy <= 1'b0;
      end else begin
        tx_left <= tx_left - 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign tx = tx_shift[0];

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // Receive sampler
  // Bit 0 is the start bit, 1-8 data, 9 mid stop, 10 end of stop
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rx_active <= 1'b0;
      rx_cnt    <= '0;
      rx_bit    <= 4'd0;
    end else if (!rx_active) begin
      if (!rx_sync) begin
        rx_active <= 1'b1;
        rx_cnt    <= HALF_LAST;
        rx_bit    <= 4'd0;
      end
    end else if (rx_cnt != '0) begin
      rx_cnt <= rx_cnt - 1'b1;
    end else begin
      rx_cnt <= BIT_LAST;
      rx_bit <= rx_bit + 4'd1;
      if ((rx_bit == 4'd0 && rx_sync) || (rx_bit == 4'd9 && !rx_sync)) begin
        // Glitch on the start bit or a framing error
        rx_active <= 1'b0;
      end else if (rx_bit == 4'd9) begin
        rx_cnt <= HALF_LAST;
      end else if (rx_bit == 4'd10) begin
        rx_active <= 1'b0;
      end
    end
  end

  assign rx_tick  = rx_active && (rx_cnt == '0);
  assign rx_store = rx_tick && (rx_bit == 4'd10);

  always_ff @(posedge clock_50) begin
    if (rx_tick && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_store) begin
      rx_buf <= rx_shift;
    end
  end

  // New byte wins over a read in the same cycle
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rx_valid <= 1'b0;
    end else if (rx_store) begin
      rx_valid <= 1'b1;
    end else if (rd_data) begin
      rx_valid <= 1'b0;
    end
  end

  always_comb begin
    data_out = 16'h0000;
    case (bus.addr[3:0])
      UART_REG_DATA: data_out = {8'h00, rx_buf};
      UART_REG_STATUS: begin
        data_out[UART_ST_TX_BUSY]  = tx_busy;
        data_out[UART_ST_RX_VALID] = rx_valid;
      end
      default: data_out = 16'h0000;
    endcase
  end

endmodule

`default_nettype wire
